// ==== logic/rv_params.svh ====
/* widths, buffer depth and opcodes for the rv32i core
   BUF_DEPTH must be a power of two; it also sets the number of fetch credits */
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// datapath
`define XLEN        32
`define REG_ADDR_W  5

// instruction buffer entries, one fetch credit each
`define BUF_DEPTH   4

`define RESET_PC    32'h80000000

// major opcodes kept by this core
`define OP_REG      7'b0110011
`define OP_IMM      7'b0010011
`define OP_LUI      7'b0110111
`define OP_AUIPC    7'b0010111
`define OP_JAL      7'b1101111
`define OP_JALR     7'b1100111
`define OP_BRANCH   7'b1100011

`endif

// ==== logic/rv_pkg.sv ====
/* shared types for the rv32i core
   inst_class_t only covers the kept opcodes, everything else is CLS_NONE */
`default_nettype none

`include "rv_params.svh"

package rv_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`XLEN-1:0]       addr_t;
    typedef logic [31:0]            inst_word_t;   // rv32 encoding, fixed
    typedef logic [`REG_ADDR_W-1:0] reg_idx_t;

    typedef enum logic [2:0] {
        CLS_R,
        CLS_I,      // op-imm and jalr
        CLS_U,      // lui, auipc
        CLS_J,
        CLS_B,
        CLS_NONE    // retires without a write
    } inst_class_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // one fetched word and the address it came from
    typedef struct packed {
        addr_t      pc;
        inst_word_t inst;
    } fetch_pkt_t;

    typedef struct packed {
        addr_t    pc;
        reg_idx_t rd;
        logic     we;
        word_t    wdata;   // result even when rd is x0
    } retire_t;

endpackage

`default_nettype wire

// ==== logic/fetch_unit.sv ====
/* issues one fetch per credit; imem answers exactly one cycle later and never stalls
   a redirect restores all credits and drops the response due on the next cycle */
`default_nettype none

`include "rv_params.svh"

module fetch_unit
    import rv_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    output logic       imem_req,
    output addr_t      imem_addr,
    input  inst_word_t imem_rdata,
    input  logic       credit_return,
    input  logic       redirect,
    input  addr_t      redirect_pc,
    output logic       push_valid,
    output fetch_pkt_t push_pkt
);

    localparam int CREDIT_W = $clog2(`BUF_DEPTH + 1);

    logic [CREDIT_W-1:0] credits;
    logic                started;       // holds off the first request one cycle
    addr_t               pc;
    logic                inflight;      // response arrives this cycle
    addr_t               inflight_pc;

    assign imem_req  = started && (credits != '0);
    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            started  <= 1'b0;
            pc       <= `RESET_PC;
            credits  <= CREDIT_W'(`BUF_DEPTH);
            inflight <= 1'b0;
        end else begin
            started  <= 1'b1;
            inflight <= imem_req && !redirect;   // wrong-path response is dropped
            if (redirect) begin
                pc      <= redirect_pc;
                credits <= CREDIT_W'(`BUF_DEPTH);
            end else begin
                if (imem_req) begin
                    pc <= pc + 32'd4;
                end
                credits <= credits - CREDIT_W'(imem_req) + CREDIT_W'(credit_return);
            end
        end
    end

    // address of the request in flight
    always_ff @(posedge clk) begin
        if (imem_req) begin
            inflight_pc <= pc;
        end
    end

    // pair returning word with its address
    assign push_valid = inflight;
    assign push_pkt   = '{pc: inflight_pc, inst: imem_rdata};

endmodule

`default_nettype wire

// ==== logic/inst_buffer.sv ====
/* fall-through instruction FIFO, no full flag since fetch credits guarantee room
   flush wins over a push or pop in the same cycle */
`default_nettype none

`include "rv_params.svh"

module inst_buffer
    import rv_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       push_valid,
    input  fetch_pkt_t push_pkt,
    input  logic       pop,
    input  logic       flush,
    output logic       buf_valid,
    output fetch_pkt_t buf_pkt,
    output logic       credit_return
);

    localparam int PTR_W = $clog2(`BUF_DEPTH);
    localparam int CNT_W = $clog2(`BUF_DEPTH + 1);

    fetch_pkt_t       mem [`BUF_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign buf_valid     = (count != '0);
    assign buf_pkt       = mem[rd_ptr];     // head visible without a pop
    assign credit_return = pop && !flush;   // redirect restores credits itself

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_valid) begin
                wr_ptr <= wr_ptr + 1'b1;   // wraps at power-of-two depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push_valid) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push_valid) begin
            mem[wr_ptr] <= push_pkt;
        end
    end

endmodule

`default_nettype wire

// ==== logic/decoder.sv ====
/* rv32i decode for alu, upper-immediate, jump and branch opcodes
   anything else decodes as CLS_NONE with a zero immediate */
`default_nettype none

`include "rv_params.svh"

module decoder
    import rv_pkg::*;
(
    input  inst_word_t  inst,
    output reg_idx_t    rs1,
    output reg_idx_t    rs2,
    output reg_idx_t    rd,
    output word_t       imm,
    output inst_class_t inst_class,
    output alu_op_t     alu_op,
    output logic [2:0]  funct3,
    output logic        is_jalr,
    output logic        is_lui
);

    logic [6:0] opcode;
    logic [6:0] funct7;

    assign opcode  = inst[6:0];
    assign funct7  = inst[31:25];
    assign funct3  = inst[14:12];
    assign rd      = inst[11:7];
    assign rs1     = inst[19:15];
    assign rs2     = inst[24:20];
    assign is_jalr = (opcode == `OP_JALR);
    assign is_lui  = (opcode == `OP_LUI);

    always_comb begin
        unique case (opcode)
            `OP_REG:              inst_class = CLS_R;
            `OP_IMM, `OP_JALR:    inst_class = CLS_I;
            `OP_LUI, `OP_AUIPC:   inst_class = CLS_U;
            `OP_JAL:              inst_class = CLS_J;
            `OP_BRANCH:           inst_class = CLS_B;
            default:              inst_class = CLS_NONE;
        endcase
    end

    // sign-extended immediate per format
    always_comb begin
        unique case (inst_class)
            CLS_I:   imm = {{20{inst[31]}}, inst[31:20]};
            CLS_U:   imm = {inst[31:12], 12'b0};
            CLS_J:   imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            CLS_B:   imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            default: imm = '0;   // R and NONE carry no immediate
        endcase
    end

    // jalr, lui, auipc, jal and branch targets all use ADD
    always_comb begin
        alu_op = ALU_ADD;
        if (inst_class == CLS_R || opcode == `OP_IMM) begin
            unique case (funct3)
                3'b000: alu_op = (inst_class == CLS_R && funct7[5]) ? ALU_SUB : ALU_ADD;
                3'b001: alu_op = ALU_SLL;
                3'b010: alu_op = ALU_SLT;
                3'b011: alu_op = ALU_SLTU;
                3'b100: alu_op = ALU_XOR;
                3'b101: alu_op = funct7[5] ? ALU_SRA : ALU_SRL;   // imm[10] for srai
                3'b110: alu_op = ALU_OR;
                3'b111: alu_op = ALU_AND;
                default: alu_op = ALU_ADD;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/regfile.sv ====
/* 32 x XLEN register file, two async reads, one write
   x0 ignores writes and always reads zero */
`default_nettype none

`include "rv_params.svh"

module regfile
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    output word_t    rdata1,
    output word_t    rdata2
);

    localparam int NREGS = 1 << `REG_ADDR_W;

    word_t regs [NREGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== logic/execute_unit.sv ====
/* single-cycle execute; pops the buffer head whenever stall is low
   retire record and register write land at the edge after the pop */
`default_nettype none

`include "rv_params.svh"

module execute_unit
    import rv_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       stall,
    input  logic       buf_valid,
    input  fetch_pkt_t buf_pkt,
    output logic       pop,
    output logic       redirect,
    output addr_t      redirect_pc,
    output logic       retire_valid,
    output retire_t    retire
);

    localparam int SHAMT_W = $clog2(`XLEN);

    reg_idx_t    rs1, rs2, rd;
    word_t       imm;
    inst_class_t inst_class;
    alu_op_t     alu_op;
    logic [2:0]  funct3;
    logic        is_jalr, is_lui;
    word_t       rs1_data, rs2_data;
    word_t       alu_a, alu_b, alu_res;
    logic        br_cond, taken, wen;
    word_t       link, wdata;

    decoder u_decoder (
        .inst       (buf_pkt.inst),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd         (rd),
        .imm        (imm),
        .inst_class (inst_class),
        .alu_op     (alu_op),
        .funct3     (funct3),
        .is_jalr    (is_jalr),
        .is_lui     (is_lui)
    );

    regfile u_regfile (
        .clk    (clk),
        .reset  (reset),
        .we     (pop && wen),
        .waddr  (rd),
        .wdata  (wdata),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    assign pop = buf_valid && !stall;

    // operand select, branches and jal compute their target here
    always_comb begin
        unique case (inst_class)
            CLS_I: begin
                alu_a = rs1_data;
                alu_b = imm;
            end
            CLS_U: begin
                alu_a = is_lui ? '0 : buf_pkt.pc;
                alu_b = imm;
            end
            CLS_J, CLS_B: begin
                alu_a = buf_pkt.pc;
                alu_b = imm;
            end
            default: begin
                alu_a = rs1_data;
                alu_b = rs2_data;
            end
        endcase
    end

    always_comb begin
        unique case (alu_op)
            ALU_ADD:  alu_res = alu_a + alu_b;
            ALU_SUB:  alu_res = alu_a - alu_b;
            ALU_SLL:  alu_res = alu_a << alu_b[SHAMT_W-1:0];
            ALU_SLT:  alu_res = word_t'($signed(alu_a) < $signed(alu_b));
            ALU_SLTU: alu_res = word_t'(alu_a < alu_b);
            ALU_XOR:  alu_res = alu_a ^ alu_b;
            ALU_SRL:  alu_res = alu_a >> alu_b[SHAMT_W-1:0];
            ALU_SRA:  alu_res = word_t'($signed(alu_a) >>> alu_b[SHAMT_W-1:0]);
            ALU_OR:   alu_res = alu_a | alu_b;
            ALU_AND:  alu_res = alu_a & alu_b;
            default:  alu_res = alu_a + alu_b;
        endcase
    end

    always_comb begin
        unique case (funct3)
            3'b000:  br_cond = (rs1_data == rs2_data);
            3'b001:  br_cond = (rs1_data != rs2_data);
            3'b100:  br_cond = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  br_cond = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  br_cond = (rs1_data < rs2_data);
            3'b111:  br_cond = (rs1_data >= rs2_data);
            default: br_cond = 1'b0;
        endcase
    end

    assign taken = (inst_class == CLS_J) || (inst_class == CLS_I && is_jalr) ||
                   (inst_class == CLS_B && br_cond);
    assign redirect    = pop && taken;
    assign redirect_pc = is_jalr ? {alu_res[`XLEN-1:1], 1'b0} : alu_res;

    // write-back select
    assign wen   = (inst_class inside {CLS_R, CLS_I, CLS_U, CLS_J});
    assign link  = buf_pkt.pc + 32'd4;
    assign wdata = (inst_class == CLS_J || is_jalr) ? link : alu_res;

    always_ff @(posedge clk) begin
        if (reset) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            retire <= '{pc: buf_pkt.pc, rd: rd, we: wen, wdata: wdata};
        end
    end

endmodule

`default_nettype wire

// ==== logic/rv_core.sv ====
/* rv32i core without loads, stores or csrs
   imem must answer every request with the word one cycle later */
`default_nettype none

module rv_core
    import rv_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       stall,
    output logic       imem_req,
    output addr_t      imem_addr,
    input  inst_word_t imem_rdata,
    output logic       retire_valid,
    output retire_t    retire
);

    logic       push_valid;
    fetch_pkt_t push_pkt;
    logic       credit_return;
    logic       pop;
    logic       buf_valid;
    fetch_pkt_t buf_pkt;
    logic       redirect;     // also flushes the buffer
    addr_t      redirect_pc;

    fetch_unit u_fetch (
        .clk           (clk),
        .reset         (reset),
        .imem_req      (imem_req),
        .imem_addr     (imem_addr),
        .imem_rdata    (imem_rdata),
        .credit_return (credit_return),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .push_valid    (push_valid),
        .push_pkt      (push_pkt)
    );

    inst_buffer u_buffer (
        .clk           (clk),
        .reset         (reset),
        .push_valid    (push_valid),
        .push_pkt      (push_pkt),
        .pop           (pop),
        .flush         (redirect),
        .buf_valid     (buf_valid),
        .buf_pkt       (buf_pkt),
        .credit_return (credit_return)
    );

    execute_unit u_execute (
        .clk          (clk),
        .reset        (reset),
        .stall        (stall),
        .buf_valid    (buf_valid),
        .buf_pkt      (buf_pkt),
        .pop          (pop),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

`default_nettype wire

// ==== testbench/rv_core_assertions.sv ====
/* concurrent checks on the fetch credits and the imem to buffer handshake
   bound into fetch_unit, so it sees the internal credit counter */
`default_nettype none

`include "rv_params.svh"

module rv_core_assertions
    import rv_pkg::*;
#(
    parameter int CREDIT_W = $clog2(`BUF_DEPTH + 1)
) (
    input wire logic                clk,
    input wire logic                reset,
    input wire logic                imem_req,
    input wire addr_t               imem_addr,
    input wire logic                credit_return,
    input wire logic                push_valid,
    input wire fetch_pkt_t          push_pkt,
    input wire logic                redirect,
    input wire logic [CREDIT_W-1:0] credits
);
    timeunit 1ns;
    timeprecision 100ps;

    credits_in_range: assert property (@(posedge clk) disable iff (reset)
        credits <= CREDIT_W'(`BUF_DEPTH))
        else $error("fetch credit count above buffer depth");

    // full credits means nothing is stored or in flight, so nothing can be popped
    no_return_at_full: assert property (@(posedge clk) disable iff (reset)
        !(credit_return && credits == CREDIT_W'(`BUF_DEPTH)))
        else $error("credit returned while all credits were already held");

    // a redirect drops the response due next cycle
    push_after_req: assert property (@(posedge clk) disable iff (reset)
        (imem_req && !redirect) |=> (push_valid && push_pkt.pc == $past(imem_addr)))
        else $error("response of an imem request was not pushed with its address");

    no_push_without_req: assert property (@(posedge clk) disable iff (reset)
        !(imem_req && !redirect) |=> !push_valid)
        else $error("push without a live imem request one cycle earlier");

endmodule

bind fetch_unit rv_core_assertions u_assertions (
    .clk           (clk),
    .reset         (reset),
    .imem_req      (imem_req),
    .imem_addr     (imem_addr),
    .credit_return (credit_return),
    .push_valid    (push_valid),
    .push_pkt      (push_pkt),
    .redirect      (redirect),
    .credits       (credits)
);

`default_nettype wire

// ==== testbench/rv_core_tb.sv ====
/* runs one program twice, first without and then with random stalls
   memory answers each request one cycle later, addresses off the program read as nop */
`default_nettype none

`include "rv_params.svh"

module rv_core_tb
    import rv_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam inst_word_t NOP_WORD = 32'h00000013;   // addi x0, x0, 0
    localparam int REQ_TIMEOUT     = 8;
    localparam int RETIRE_TIMEOUT  = 64;

    logic       clk;
    logic       reset;
    logic       stall;
    logic       imem_req;
    addr_t      imem_addr;
    inst_word_t imem_rdata;
    logic       retire_valid;
    retire_t    retire;

    inst_word_t prog [64];
    retire_t    expected [$];   // in retire order, wrong path left out
    word_t      mem_index;
    logic       stall_enable;
    logic       timed_out = 1'b0;
    int         checks = 0;
    int         errors = 0;

    rv_core DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // one-cycle instruction memory
    assign mem_index = (imem_addr - `RESET_PC) >> 2;

    always @(posedge clk) begin
        if (imem_req) begin
            imem_rdata <= (mem_index < 32'd64) ? prog[mem_index[5:0]] : NOP_WORD;
        end
    end

    always @(posedge clk) begin
        stall <= stall_enable && (($urandom % 3) == 0);   // about one cycle in three
    end

    // rv32i encoders
    function automatic inst_word_t r_type(input logic [6:0] f7, input reg_idx_t rs2,
                                          input reg_idx_t rs1, input logic [2:0] f3,
                                          input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, `OP_REG};
    endfunction

    function automatic inst_word_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                          input logic [2:0] f3, input reg_idx_t rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic inst_word_t u_type(input logic [19:0] imm, input reg_idx_t rd,
                                          input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic inst_word_t jal_word(input logic [20:0] off, input reg_idx_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, `OP_JAL};
    endfunction

    function automatic inst_word_t branch_word(input logic [12:0] off, input reg_idx_t rs2,
                                               input reg_idx_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OP_BRANCH};
    endfunction

    task automatic program_step(input int idx, input inst_word_t w, input reg_idx_t rd,
                                input logic we, input word_t wdata);
        retire_t want;
        prog[idx[5:0]] = w;
        want = '{pc: `RESET_PC + 32'(4 * idx), rd: rd, we: we, wdata: wdata};
        expected.push_back(want);
    endtask

    task automatic wrong_path(input int idx, input inst_word_t w);
        prog[idx[5:0]] = w;   // must never retire
    endtask

    // x1 = 5 and x2 = -3 feed most of the later checks
    task automatic load_program();
        int i;
        for (i = 0; i < 64; i++) begin
            prog[i[5:0]] = NOP_WORD;
        end
        program_step(0,  i_type(12'd5, 5'd0, 3'b000, 5'd1, `OP_IMM), 5'd1, 1'b1, 32'h5);
        program_step(1,  i_type(12'hffd, 5'd0, 3'b000, 5'd2, `OP_IMM), 5'd2, 1'b1, 32'hfffffffd);
        program_step(2,  r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 5'd3, 1'b1, 32'h2);
        program_step(3,  r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), 5'd4, 1'b1, 32'h8);  // sub
        program_step(4,  r_type(7'h20, 5'd1, 5'd2, 3'b101, 5'd5), 5'd5, 1'b1, 32'hffffffff);
        program_step(5,  i_type(12'h401, 5'd2, 3'b101, 5'd5, `OP_IMM), 5'd5, 1'b1, 32'hfffffffe);
        program_step(6,  r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd6), 5'd6, 1'b1, 32'h1);  // slt
        program_step(7,  r_type(7'h00, 5'd1, 5'd2, 3'b011, 5'd7), 5'd7, 1'b1, 32'h0);  // sltu
        program_step(8,  i_type(12'hfff, 5'd1, 3'b010, 5'd6, `OP_IMM), 5'd6, 1'b1, 32'h0);
        program_step(9,  i_type(12'hfff, 5'd1, 3'b011, 5'd7, `OP_IMM), 5'd7, 1'b1, 32'h1);
        program_step(10, u_type(20'h12345, 5'd8, `OP_LUI), 5'd8, 1'b1, 32'h12345000);
        program_step(11, u_type(20'h00001, 5'd9, `OP_AUIPC), 5'd9, 1'b1, 32'h8000102c);
        program_step(12, i_type(12'd7, 5'd1, 3'b000, 5'd0, `OP_IMM), 5'd0, 1'b1, 32'hc);
        program_step(13, r_type(7'h00, 5'd1, 5'd0, 3'b000, 5'd10), 5'd10, 1'b1, 32'h5);
        program_step(14, branch_word(13'd8, 5'd2, 5'd1, 3'b000), 5'd0, 1'b0, 32'h0);  // beq
        program_step(15, branch_word(13'd8, 5'd2, 5'd1, 3'b001), 5'd0, 1'b0, 32'h0);  // bne
        wrong_path(16, i_type(12'd99, 5'd0, 3'b000, 5'd11, `OP_IMM));
        program_step(17, jal_word(21'd8, 5'd12), 5'd12, 1'b1, 32'h80000048);
        wrong_path(18, i_type(12'd98, 5'd0, 3'b000, 5'd11, `OP_IMM));
        // target 0x80000055, bit 0 cleared
        program_step(19, i_type(12'd13, 5'd12, 3'b000, 5'd13, `OP_JALR), 5'd13, 1'b1,
                     32'h80000050);
        wrong_path(20, i_type(12'd97, 5'd0, 3'b000, 5'd11, `OP_IMM));
        program_step(21, branch_word(13'd8, 5'd1, 5'd2, 3'b100), 5'd0, 1'b0, 32'h0);  // blt
        wrong_path(22, i_type(12'd96, 5'd0, 3'b000, 5'd11, `OP_IMM));
        program_step(23, branch_word(13'd8, 5'd1, 5'd2, 3'b101), 5'd0, 1'b0, 32'h0);  // bge
        program_step(24, branch_word(13'd8, 5'd1, 5'd2, 3'b110), 5'd0, 1'b0, 32'h0);  // bltu
        program_step(25, branch_word(13'd8, 5'd1, 5'd2, 3'b111), 5'd0, 1'b0, 32'h0);  // bgeu
        wrong_path(26, i_type(12'd95, 5'd0, 3'b000, 5'd11, `OP_IMM));
        program_step(27, i_type(12'h0ff, 5'd1, 3'b100, 5'd14, `OP_IMM), 5'd14, 1'b1, 32'hfa);
        program_step(28, i_type(12'd4, 5'd1, 3'b001, 5'd15, `OP_IMM), 5'd15, 1'b1, 32'h50);
        program_step(29, r_type(7'h00, 5'd1, 5'd2, 3'b101, 5'd16), 5'd16, 1'b1, 32'h07ffffff);
        program_step(30, r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd17), 5'd17, 1'b1, 32'hfffffffd);
        program_step(31, r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd18), 5'd18, 1'b1, 32'h5);
        program_step(32, 32'h00000073, 5'd0, 1'b0, 32'h0);   // ecall, not supported
        program_step(33, jal_word(21'd0, 5'd0), 5'd0, 1'b1, 32'h80000088);   // parks here
    endtask

    task automatic check_value(input string name, input word_t got, input word_t want);
        checks++;
        assert (got == want) else begin
            $display("ERROR: %s got %h expected %h", name, got, want);
            errors++;
        end
    endtask

    task automatic check_retire(input retire_t want);
        check_value("retire.pc", retire.pc, want.pc);
        check_value("retire.we", word_t'(retire.we), word_t'(want.we));
        if (want.we) begin
            check_value("retire.rd", word_t'(retire.rd), word_t'(want.rd));
            check_value("retire.wdata", retire.wdata, want.wdata);
        end
    endtask

    task automatic run_program(input logic stalls_on);
        int cycles;
        int k;
        @(posedge clk);
        reset        <= 1'b1;
        stall_enable <= stalls_on;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("retire_valid", word_t'(retire_valid), 32'h0);
        check_value("imem_req", word_t'(imem_req), 32'h0);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!imem_req && cycles < REQ_TIMEOUT);
        if (!imem_req) begin
            $display("timeout: no fetch request after reset was released");
            errors++;
            timed_out = 1'b1;
        end else begin
            check_value("cycles to first imem_req", word_t'(cycles), 32'h1);
            check_value("imem_addr", imem_addr, `RESET_PC);
        end
        for (k = 0; k < expected.size() && !timed_out; k++) begin
            cycles = 0;
            do begin
                @(negedge clk);
                cycles++;
            end while (!retire_valid && cycles < RETIRE_TIMEOUT);
            if (!retire_valid) begin
                $display("timeout: retire %0d of %0d never arrived", k, expected.size());
                errors++;
                timed_out = 1'b1;
            end else begin
                check_retire(expected[k]);
            end
        end
    endtask

    initial begin
        reset        = 1'b1;
        stall        = 1'b0;
        imem_rdata   = '0;
        stall_enable = 1'b0;
        void'($urandom(32'hec07));
        load_program();
        run_program(1'b0);
        if (!timed_out) begin
            run_program(1'b1);   // same table, random back-pressure
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+logic
logic/rv_pkg.sv
logic/fetch_unit.sv
logic/inst_buffer.sv
logic/decoder.sv
logic/regfile.sv
logic/execute_unit.sv
logic/rv_core.sv
testbench/rv_core_assertions.sv
testbench/rv_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds rv_core_tb with Verilator, runs it and scans the log
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
FAIL_TEXT="Simulation finished: FAIL"

verilator --binary --timing --assert -f compile.f --top-module rv_core_tb -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vrv_core_tb" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "$FAIL_TEXT" "$LOG_FILE"; then
    echo "testbench reported failure"
    exit 1
fi

echo "testbench reported no failure"
exit 0
